/* hdl/async_fifo.sv */
//------------------------------
// async_fifo
// Dual clock FIFO top level with
// Gray pointer crossings
//------------------------------
`timescale 1ns/1ps
`include "async_fifo_macros.svh"

module async_fifo (
    input  logic                  wr_clk_i,
    input  logic                  rd_clk_i,
    input  logic                  rst_n_i,
    input  logic                  push_i,
    input  logic                  pop_i,
    input  async_fifo_pkg::data_t wr_data_i,
    output async_fifo_pkg::data_t rd_data_o,
    output logic                  full_o,
    output logic                  a_full_o,
    output logic                  empty_o,
    output logic                  a_empty_o
);

    // Write clock domain
    logic                  wr_en;
    async_fifo_pkg::addr_t wr_addr;
    async_fifo_pkg::ptr_t  wr_ptr;
    async_fifo_pkg::ptr_t  wq_rd_ptr;   // Read pointer seen by writer

    // Read clock domain
    logic                  rd_en;
    async_fifo_pkg::addr_t rd_addr;
    async_fifo_pkg::ptr_t  rd_ptr;
    async_fifo_pkg::ptr_t  rq_wr_ptr;   // Write pointer seen by reader

    wr_ptr_full i_wr_ptr_full (
        .wr_clk_i   (wr_clk_i),
        .rst_n_i    (rst_n_i),
        .push_i     (push_i),
        .rptr_sync_i(wq_rd_ptr),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_ptr_o   (wr_ptr),
        .full_o     (full_o),
        .a_full_o   (a_full_o)
    );

    rd_ptr_empty i_rd_ptr_empty (
        .rd_clk_i   (rd_clk_i),
        .rst_n_i    (rst_n_i),
        .pop_i      (pop_i),
        .wptr_sync_i(rq_wr_ptr),
        .rd_en_o    (rd_en),
        .rd_addr_o  (rd_addr),
        .rd_ptr_o   (rd_ptr),
        .empty_o    (empty_o),
        .a_empty_o  (a_empty_o)
    );

    ram_dp_2clk i_ram_dp_2clk (
        .wr_clk_i (wr_clk_i),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data_i),
        .rd_clk_i (rd_clk_i),
        .rst_n_i  (rst_n_i),
        .rd_en_i  (rd_en),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data_o)
    );

    // Read pointer into the write clock
    cdc_sync #(
        .STAGES(`CDC_STAGES)
    ) i_sync_rd2wr (
        .clk_i  (wr_clk_i),
        .rst_n_i(rst_n_i),
        .ptr_i  (rd_ptr),
        .ptr_o  (wq_rd_ptr)
    );

    // Write pointer into the read clock
    cdc_sync #(
        .STAGES(`CDC_STAGES)
    ) i_sync_wr2rd (
        .clk_i  (rd_clk_i),
        .rst_n_i(rst_n_i),
        .ptr_i  (wr_ptr),
        .ptr_o  (rq_wr_ptr)
    );

endmodule

/* hdl/async_fifo_macros.svh */
//------------------------------
// Async FIFO configuration
// Data width, depth, synchronizer
// length and almost-flag gaps
//------------------------------
`ifndef ASYNC_FIFO_MACROS_SVH
`define ASYNC_FIFO_MACROS_SVH

// Data word width in bits
`define FIFO_WIDTH 32

// Number of entries, power of two
`define FIFO_DEPTH 16

`define FIFO_ADDR_W $clog2(`FIFO_DEPTH)

// Flops per pointer crossing
`define CDC_STAGES 2

// Almost full while free slots <= gap
`define A_FULL_GAP 2

// Almost empty while stored words <= gap
`define A_EMPTY_GAP 2

`endif

/* hdl/async_fifo_pkg.sv */
//------------------------------
// Async FIFO package
// Data, address and pointer types
// Gray code helpers
//------------------------------
`include "async_fifo_macros.svh"

package async_fifo_pkg;

    typedef logic [`FIFO_WIDTH-1:0]  data_t;
    typedef logic [`FIFO_ADDR_W-1:0] addr_t;
    typedef logic [`FIFO_ADDR_W:0]   ptr_t;   // One extra wrap bit

    function automatic ptr_t bin2gray(input ptr_t bin);
        return (bin >> 1) ^ bin;
    endfunction

    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
        for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

/* hdl/cdc_sync.sv */
//------------------------------
// cdc_sync
// Flop chain moving a Gray pointer
// into the receiving clock domain
//------------------------------
`timescale 1ns/1ps

module cdc_sync #(
    parameter int STAGES = 2
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  async_fifo_pkg::ptr_t ptr_i,
    output async_fifo_pkg::ptr_t ptr_o
);

    async_fifo_pkg::ptr_t sync_q [STAGES];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= ptr_i;   // First flop may go metastable
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign ptr_o = sync_q[STAGES-1];

    // Only one bit of a Gray pointer may change per receiving edge
    a_gray_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $countones(sync_q[0] ^ $past(sync_q[0])) <= 1);

endmodule

/* hdl/ram_dp_2clk.sv */
//------------------------------
// ram_dp_2clk
// Two clock dual-port memory with
// registered read port
//------------------------------
`timescale 1ns/1ps
`include "async_fifo_macros.svh"

module ram_dp_2clk (
    input  logic                  wr_clk_i,
    input  logic                  wr_en_i,
    input  async_fifo_pkg::addr_t wr_addr_i,
    input  async_fifo_pkg::data_t wr_data_i,
    input  logic                  rd_clk_i,
    input  logic                  rst_n_i,
    input  logic                  rd_en_i,
    input  async_fifo_pkg::addr_t rd_addr_i,
    output async_fifo_pkg::data_t rd_data_o
);

    async_fifo_pkg::data_t mem [`FIFO_DEPTH];

    always_ff @(posedge wr_clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Output word holds until the next accepted pop
    always_ff @(posedge rd_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* hdl/rd_ptr_empty.sv */
//------------------------------
// rd_ptr_empty
// Read pointer, pop acceptance,
// empty and almost empty flags
//------------------------------
`timescale 1ns/1ps
`include "async_fifo_macros.svh"

module rd_ptr_empty (
    input  logic                  rd_clk_i,
    input  logic                  rst_n_i,
    input  logic                  pop_i,
    input  async_fifo_pkg::ptr_t  wptr_sync_i,
    output logic                  rd_en_o,
    output async_fifo_pkg::addr_t rd_addr_o,
    output async_fifo_pkg::ptr_t  rd_ptr_o,
    output logic                  empty_o,
    output logic                  a_empty_o
);

    localparam int AW = `FIFO_ADDR_W;

    async_fifo_pkg::ptr_t rd_bin;
    async_fifo_pkg::ptr_t rd_gray;
    async_fifo_pkg::ptr_t rd_bin_next;
    async_fifo_pkg::ptr_t rd_gray_next;
    async_fifo_pkg::ptr_t wr_bin_sync;
    async_fifo_pkg::ptr_t rd_level;
    logic                 empty_next;
    logic                 a_empty_next;

    assign rd_en_o = pop_i & ~empty_o;

    assign rd_bin_next  = rd_bin + async_fifo_pkg::ptr_t'(rd_en_o);
    assign rd_gray_next = async_fifo_pkg::bin2gray(rd_bin_next);

    // Caught up with the write pointer
    assign empty_next = (rd_gray_next == wptr_sync_i);

    // Stored words as seen from the read side
    assign wr_bin_sync  = async_fifo_pkg::gray2bin(wptr_sync_i);
    assign rd_level     = wr_bin_sync - rd_bin_next;
    assign a_empty_next = (rd_level <= async_fifo_pkg::ptr_t'(`A_EMPTY_GAP));

    always_ff @(posedge rd_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_bin    <= '0;
            rd_gray   <= '0;
            empty_o   <= 1'b1;   // Nothing stored yet
            a_empty_o <= 1'b1;
        end else begin
            rd_bin    <= rd_bin_next;
            rd_gray   <= rd_gray_next;
            empty_o   <= empty_next;
            a_empty_o <= a_empty_next;
        end
    end

    assign rd_addr_o = rd_bin[AW-1:0];
    assign rd_ptr_o  = rd_gray;   // Crosses to the write clock

    a_no_adv_empty: assert property (@(posedge rd_clk_i) disable iff (!rst_n_i)
        empty_o |=> (rd_bin == $past(rd_bin)));

endmodule

/* hdl/wr_ptr_full.sv */
//------------------------------
// wr_ptr_full
// Write pointer, push acceptance,
// full and almost full flags
//------------------------------
`timescale 1ns/1ps
`include "async_fifo_macros.svh"

module wr_ptr_full (
    input  logic                  wr_clk_i,
    input  logic                  rst_n_i,
    input  logic                  push_i,
    input  async_fifo_pkg::ptr_t  rptr_sync_i,
    output logic                  wr_en_o,
    output async_fifo_pkg::addr_t wr_addr_o,
    output async_fifo_pkg::ptr_t  wr_ptr_o,
    output logic                  full_o,
    output logic                  a_full_o
);

    localparam int AW = `FIFO_ADDR_W;

    async_fifo_pkg::ptr_t wr_bin;
    async_fifo_pkg::ptr_t wr_gray;
    async_fifo_pkg::ptr_t wr_bin_next;
    async_fifo_pkg::ptr_t wr_gray_next;
    async_fifo_pkg::ptr_t rd_bin_sync;
    async_fifo_pkg::ptr_t rptr_full_cmp;
    async_fifo_pkg::ptr_t wr_level;
    logic                 full_next;
    logic                 a_full_next;

    assign wr_en_o = push_i & ~full_o;

    assign wr_bin_next  = wr_bin + async_fifo_pkg::ptr_t'(wr_en_o);
    assign wr_gray_next = async_fifo_pkg::bin2gray(wr_bin_next);

    // Read pointer one lap behind: top two Gray bits flipped
    assign rptr_full_cmp = {~rptr_sync_i[AW:AW-1], rptr_sync_i[AW-2:0]};
    assign full_next     = (wr_gray_next == rptr_full_cmp);

    // Fill level seen from the write side, never below the true level
    assign rd_bin_sync = async_fifo_pkg::gray2bin(rptr_sync_i);
    assign wr_level    = wr_bin_next - rd_bin_sync;
    assign a_full_next = (wr_level >= async_fifo_pkg::ptr_t'(`FIFO_DEPTH - `A_FULL_GAP));

    always_ff @(posedge wr_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_bin   <= '0;
            wr_gray  <= '0;
            full_o   <= 1'b0;
            a_full_o <= 1'b0;
        end else begin
            wr_bin   <= wr_bin_next;
            wr_gray  <= wr_gray_next;
            full_o   <= full_next;
            a_full_o <= a_full_next;
        end
    end

    assign wr_addr_o = wr_bin[AW-1:0];
    assign wr_ptr_o  = wr_gray;   // Crosses to the read clock

    a_no_adv_full: assert property (@(posedge wr_clk_i) disable iff (!rst_n_i)
        full_o |=> (wr_bin == $past(wr_bin)));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the async FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module async_fifo_tb \
    -f sources.f \
    --Mdir "$BUILD_DIR" \
    -o async_fifo_tb

"./$BUILD_DIR/async_fifo_tb" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^TEST OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

/* sim/async_fifo_tb.sv */
//------------------------------
// async_fifo_tb
// Pattern driven testbench with a
// model queue for data and flags
//------------------------------
`timescale 1ns/1ps
`include "async_fifo_macros.svh"

module async_fifo_tb;

    localparam int RESET_CYCLES    = 3;
    localparam int CYCLES_PER_LINE = 40;

    logic                  wr_clk;
    logic                  rd_clk;
    logic                  rst_n;
    logic                  push;
    logic                  pop;
    async_fifo_pkg::data_t wr_data;
    async_fifo_pkg::data_t rd_data;
    logic                  full;
    logic                  a_full;
    logic                  empty;
    logic                  a_empty;

    byte                   cmd_q[$];
    async_fifo_pkg::data_t arg_q[$];
    int                    line_q[$];
    async_fifo_pkg::data_t model_q[$];
    async_fifo_pkg::data_t last_word   = '0;   // What rd_data_o holds between pops
    int                    dropped     = 0;
    int                    cycle_cnt   = 0;
    int                    cycle_limit = 0;

    tb_clk_gen #(.PERIOD_NS(8.0), .PHASE_NS(0.0)) i_wr_clk_gen (.clk_o(wr_clk));
    tb_clk_gen #(.PERIOD_NS(8.0), .PHASE_NS(3.0)) i_rd_clk_gen (.clk_o(rd_clk));

    async_fifo DUT (
        .wr_clk_i (wr_clk),
        .rd_clk_i (rd_clk),
        .rst_n_i  (rst_n),
        .push_i   (push),
        .pop_i    (pop),
        .wr_data_i(wr_data),
        .rd_data_o(rd_data),
        .full_o   (full),
        .a_full_o (a_full),
        .empty_o  (empty),
        .a_empty_o(a_empty)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic load_patterns();
        int                    fd;
        int                    n;
        int                    line_no;
        string                 line;
        byte                   cmd;
        async_fifo_pkg::data_t arg;
        fd = $fopen("sim/fifo_patterns.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open sim/fifo_patterns.txt for reading");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n == 0 || line.len() < 3 || line.getc(0) == "#") begin
                continue;   // Blank or comment line
            end
            cmd = line.getc(0);
            if (cmd == "I") begin
                n = $sscanf(line, "%c %d", cmd, arg);
            end else begin
                n = $sscanf(line, "%c %h", cmd, arg);
            end
            if (n != 2) begin
                stop_on_error($sformatf("Pattern line %0d could not be parsed", line_no));
            end
            cmd_q.push_back(cmd);
            arg_q.push_back(arg);
            line_q.push_back(line_no);
        end
        $fclose(fd);
    endtask

    task automatic push_word(input async_fifo_pkg::data_t word);
        @(negedge wr_clk);
        push    = 1'b1;
        wr_data = word;
        if (model_q.size() == `FIFO_DEPTH) begin
            dropped++;   // No room, the DUT discards it
        end else begin
            model_q.push_back(word);
        end
        @(negedge wr_clk);
        push = 1'b0;
    endtask

    task automatic pop_word(input async_fifo_pkg::data_t file_word, input int line_no);
        async_fifo_pkg::data_t exp_word;
        if (model_q.size() == 0) begin
            exp_word = last_word;   // Ignored pop leaves the output alone
        end else begin
            exp_word = model_q.pop_front();
        end
        assert (file_word == exp_word) else
            stop_on_error($sformatf("Pattern line %0d expects %h but the model gives %h",
                                    line_no, file_word, exp_word));
        last_word = exp_word;
        @(negedge rd_clk);
        pop = 1'b1;
        @(negedge rd_clk);
        pop = 1'b0;
        assert (rd_data == exp_word) else
            stop_on_error($sformatf("Mismatch at %0d ns: rd_data_o is %h, expected %h",
                                    $time, rd_data, exp_word));
    endtask

    task automatic check_flag(input byte cmd, input logic file_bit, input int line_no);
        int    level;
        logic  exp_bit;
        logic  dut_bit;
        string name;
        level = model_q.size();
        if (cmd == "F" || cmd == "A") begin
            @(negedge wr_clk);
        end else begin
            @(negedge rd_clk);
        end
        case (cmd)
            "F": begin
                name    = "full_o";
                exp_bit = (level == `FIFO_DEPTH);
                dut_bit = full;
            end
            "A": begin
                name    = "a_full_o";
                exp_bit = ((`FIFO_DEPTH - level) <= `A_FULL_GAP);
                dut_bit = a_full;
            end
            "E": begin
                name    = "empty_o";
                exp_bit = (level == 0);
                dut_bit = empty;
            end
            default: begin
                name    = "a_empty_o";
                exp_bit = (level <= `A_EMPTY_GAP);
                dut_bit = a_empty;
            end
        endcase
        assert (file_bit == exp_bit) else
            stop_on_error($sformatf("Pattern line %0d expects %s = %b against a model level of %0d",
                                    line_no, name, file_bit, level));
        assert (dut_bit == exp_bit) else
            stop_on_error($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
                                    $time, name, dut_bit, exp_bit));
    endtask

    // Run limit grows with the pattern file
    always @(posedge wr_clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_on_error($sformatf("Timeout after %0d write clock cycles", cycle_cnt));
        end
    end

    initial begin
        rst_n   = 1'b0;
        push    = 1'b0;
        pop     = 1'b0;
        wr_data = '0;
        load_patterns();
        cycle_limit = CYCLES_PER_LINE * cmd_q.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(negedge wr_clk);
        rst_n = 1'b1;   // Both clocks already running
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "W": push_word(arg_q[i]);
                "R": pop_word(arg_q[i], line_q[i]);
                "I": repeat (arg_q[i]) @(negedge wr_clk);
                "F", "A", "E", "B": check_flag(cmd_q[i], arg_q[i][0], line_q[i]);
                default: stop_on_error($sformatf("Unknown command on pattern line %0d",
                                                 line_q[i]));
            endcase
        end
        if (model_q.size() == 0) begin
            $display("%0d pattern lines run, %0d pushes dropped", cmd_q.size(), dropped);
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d words left in the model after the last pattern",
                                    model_q.size()));
        end
    end

endmodule

/* sim/fifo_patterns.txt */
# cmd arg: W hex word push, R hex word pop and expect, I decimal idle cycles
# F A E B with a bit: expect full, almost full, empty, almost empty
I 5
E 1
B 1
F 0
A 0
R 00000000
I 5
E 1
W a0000001
W a0000002
W a0000003
I 5
E 0
B 0
R a0000001
W a0000004
R a0000002
W a0000005
R a0000003
I 5
B 1
R a0000004
R a0000005
W b0000000
W b0000001
W b0000002
W b0000003
W b0000004
W b0000005
W b0000006
W b0000007
W b0000008
W b0000009
W b000000a
W b000000b
W b000000c
W b000000d
I 5
A 1
F 0
W b000000e
W b000000f
I 5
F 1
W deadbeef
R b0000000
I 6
F 0
R b0000001
R b0000002
R b0000003
R b0000004
R b0000005
R b0000006
R b0000007
R b0000008
R b0000009
R b000000a
R b000000b
R b000000c
R b000000d
I 5
B 1
R b000000e
R b000000f
I 5
E 1
W c0000000
W c0000001
W c0000002
W c0000003
W c0000004
W c0000005
W c0000006
W c0000007
W c0000008
W c0000009
W c000000a
W c000000b
R c0000000
R c0000001
R c0000002
R c0000003
R c0000004
R c0000005
R c0000006
R c0000007
R c0000008
R c0000009
R c000000a
R c000000b
I 5
E 1

/* sim/tb_clk_gen.sv */
//------------------------------
// tb_clk_gen
// Free running testbench clock
// with period and start phase
//------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 8.0,
    parameter real PHASE_NS  = 0.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        #(PHASE_NS);   // Offset against the other clock
        forever begin
            #(PERIOD_NS / 2.0);
            clk_o = ~clk_o;
        end
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/async_fifo_pkg.sv
hdl/cdc_sync.sv
hdl/wr_ptr_full.sv
hdl/rd_ptr_empty.sv
hdl/ram_dp_2clk.sv
hdl/async_fifo.sv
sim/tb_clk_gen.sv
sim/async_fifo_tb.sv
